//--- Bender.yml
package:
  name: cpu_execute_unit

sources:
  - files:
      - source/cpuAluPkg.sv
      - source/aluCore.sv
      - source/nonRestoringDivider.sv
      - source/registerFile.sv
      - source/executeSequencer.sv
      - source/cpuExecuteUnit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cpuExecuteUnitTb.sv

//--- list.f
+incdir+verif
source/cpuAluPkg.sv
source/aluCore.sv
source/nonRestoringDivider.sv
source/registerFile.sv
source/executeSequencer.sv
source/cpuExecuteUnit.sv
verif/cpuExecuteUnitTb.sv

//--- source/aluCore.sv
/* Purely combinational ALU; DIV returns zero here and is done by the divider.
   Shift amounts use all of b, rotates use b modulo the word width. */
`timescale 1ns/1ps

module aluCore (
	input cpuAluPkg::aluOpE opcode,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] a,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] b,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] resultHigh,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] resultLow
);
	import cpuAluPkg::*;

	localparam int SHIFT_BITS = $clog2(DATA_WIDTH);
	localparam int PAIRS = DATA_WIDTH / 2;

	// ripple-carry adder from per-bit full adder equations
	function automatic logic [DATA_WIDTH-1:0] rippleAdd(
		input logic [DATA_WIDTH-1:0] x,
		input logic [DATA_WIDTH-1:0] y,
		input logic carryIn
	);
		logic [DATA_WIDTH:0] carry;
		logic [DATA_WIDTH-1:0] sum;
		carry[0] = carryIn;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			sum[i] = x[i] ^ y[i] ^ carry[i];
			// majority of the three inputs
			carry[i+1] = (x[i] & y[i]) | (x[i] & carry[i]) | (y[i] & carry[i]);
		end
		return sum;
	endfunction

	// signed multiply, radix-4 booth with bit-pair recoding
	// m is the multiplicand, q the multiplier
	function automatic logic [2*DATA_WIDTH-1:0] boothMul(
		input logic [DATA_WIDTH-1:0] m,
		input logic [DATA_WIDTH-1:0] q
	);
		logic [2*DATA_WIDTH-1:0] acc;
		logic [2*DATA_WIDTH-1:0] mExt;
		logic [DATA_WIDTH:0] qPad;
		logic [2:0] triplet;
		acc = '0;
		mExt = {{DATA_WIDTH{m[DATA_WIDTH-1]}}, m};
		// implied zero to the right of bit 0
		qPad = {q, 1'b0};
		for (int i = 0; i < PAIRS; i++) begin
			triplet = qPad[2*i +: 3];
			case (triplet)
				// recoded digit +1
				3'b001, 3'b010: acc = acc + (mExt << (2 * i));
				// +2
				3'b011: acc = acc + (mExt << (2 * i + 1));
				// -2
				3'b100: acc = acc - (mExt << (2 * i + 1));
				// -1
				3'b101, 3'b110: acc = acc - (mExt << (2 * i));
				// 000 and 111 recode to zero
				default: acc = acc;
			endcase
		end
		return acc;
	endfunction

	logic [2*DATA_WIDTH-1:0] product;
	logic [2*DATA_WIDTH-1:0] doubled;
	logic [2*DATA_WIDTH-1:0] rotRight;
	logic [2*DATA_WIDTH-1:0] rotLeft;
	logic [SHIFT_BITS-1:0] amount;
	logic bigShift;

	assign product = boothMul(a, b);

	// any bit above the 5-bit amount means a shift past the word
	assign amount = b[SHIFT_BITS-1:0];
	assign bigShift = |b[DATA_WIDTH-1:SHIFT_BITS];

	// rotates taken from a doubled copy of a
	assign doubled = {a, a};
	assign rotRight = doubled >> amount;
	assign rotLeft = doubled << amount;

	always_comb begin
		resultHigh = '0;
		resultLow = '0;
		case (opcode)
			ADD: resultLow = rippleAdd(a, b, 1'b0);
			// a plus two's complement of b, single increment via carry in
			SUB: resultLow = rippleAdd(a, ~b, 1'b1);
			SHR: resultLow = bigShift ? '0 : (a >> amount);
			SHRA: begin
				if (bigShift) begin
					resultLow = {DATA_WIDTH{a[DATA_WIDTH-1]}};
				end else begin
					resultLow = $signed(a) >>> amount;
				end
			end
			SHL: resultLow = bigShift ? '0 : (a << amount);
			ROR: resultLow = rotRight[DATA_WIDTH-1:0];
			ROL: resultLow = rotLeft[2*DATA_WIDTH-1:DATA_WIDTH];
			AND: resultLow = a & b;
			OR: resultLow = a | b;
			// only op that fills the high word
			MUL: {resultHigh, resultLow} = product;
			NEG: resultLow = rippleAdd('0, ~b, 1'b1);
			NOT: resultLow = ~b;
			INCPC: resultLow = rippleAdd(b, '0, 1'b1);
			// DIV and unknown codes give zero
			default: resultLow = '0;
		endcase
	end

endmodule

//--- source/cpuAluPkg.sv
/* Shared opcode and sequencer state encodings for the execute stage.
   Codes follow the CPU documentation; INCPC is a local addition. */
package cpuAluPkg;

	// one word, width of every register and operand
	localparam int DATA_WIDTH = 32;

	// 5-bit opcodes as documented, unlisted codes are treated as unknown
	typedef enum logic [4:0] {
		ADD   = 5'b00011,
		SUB   = 5'b00100,
		SHR   = 5'b00101,
		SHRA  = 5'b00110,
		SHL   = 5'b00111,
		ROR   = 5'b01000,
		ROL   = 5'b01001,
		AND   = 5'b01010,
		OR    = 5'b01011,
		MUL   = 5'b01111,
		DIV   = 5'b10000,
		NEG   = 5'b10001,
		NOT   = 5'b10010,
		// pc increment, operand b plus one
		INCPC = 5'b10011
	} aluOpE;

	// execute sequencer states
	typedef enum logic [2:0] {
		IDLE,
		// operands handed to the divider
		OPERAND,
		// alu result goes into z
		EXECUTE,
		// waiting on the iterative divider
		DIVIDE,
		WRITEBACK
	} seqStateE;

endpackage

//--- source/cpuExecuteUnit.sv
/* Execute stage top; NUM_REGS must be a power of two from 4 to 32.
   Load the register file only while busy is low. */
`timescale 1ns/1ps

module cpuExecuteUnit #(
	parameter int NUM_REGS = 16
) (
	input logic clock,
	input logic arstN,
	input logic loadEn,
	input logic [$clog2(NUM_REGS)-1:0] loadAddr,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] loadData,
	input logic [$clog2(NUM_REGS)-1:0] readAddr,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] readData,
	input logic start,
	input cpuAluPkg::aluOpE opcode,
	input logic [$clog2(NUM_REGS)-1:0] srcA,
	input logic [$clog2(NUM_REGS)-1:0] srcB,
	input logic [$clog2(NUM_REGS)-1:0] dest,
	output logic busy,
	output logic done,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] hi,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] lo
);
	import cpuAluPkg::*;

	localparam int ADDR_W = $clog2(NUM_REGS);

	// register file read and writeback
	logic [ADDR_W-1:0] rdAddrA;
	logic [ADDR_W-1:0] rdAddrB;
	logic [DATA_WIDTH-1:0] rdDataA;
	logic [DATA_WIDTH-1:0] rdDataB;
	logic wbEn;
	logic [ADDR_W-1:0] wbAddr;
	logic [DATA_WIDTH-1:0] wbData;
	logic hiLoEn;
	logic [DATA_WIDTH-1:0] hiData;
	logic [DATA_WIDTH-1:0] loData;

	// alu side
	aluOpE aluOp;
	logic [DATA_WIDTH-1:0] yA;
	logic [DATA_WIDTH-1:0] yB;
	logic [DATA_WIDTH-1:0] resultHigh;
	logic [DATA_WIDTH-1:0] resultLow;

	// divider side
	logic divStart;
	logic [DATA_WIDTH-1:0] dividend;
	logic [DATA_WIDTH-1:0] divisor;
	logic divDone;
	logic [DATA_WIDTH-1:0] quotient;
	logic [DATA_WIDTH-1:0] remainder;

	registerFile #(
		.NUM_REGS(NUM_REGS)
	) i_registerFile (
		.clock(clock),
		.arstN(arstN),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.readAddr(readAddr),
		.readData(readData),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.hiLoEn(hiLoEn),
		.hiData(hiData),
		.loData(loData),
		.hi(hi),
		.lo(lo)
	);

	executeSequencer #(
		.NUM_REGS(NUM_REGS)
	) i_executeSequencer (
		.clock(clock),
		.arstN(arstN),
		.start(start),
		.opcode(opcode),
		.srcA(srcA),
		.srcB(srcB),
		.dest(dest),
		.busy(busy),
		.done(done),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.aluOp(aluOp),
		.yA(yA),
		.yB(yB),
		.resultHigh(resultHigh),
		.resultLow(resultLow),
		.divStart(divStart),
		.dividend(dividend),
		.divisor(divisor),
		.divDone(divDone),
		.quotient(quotient),
		.remainder(remainder),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.hiLoEn(hiLoEn),
		.hiData(hiData),
		.loData(loData)
	);

	aluCore i_aluCore (
		.opcode(aluOp),
		.a(yA),
		.b(yB),
		.resultHigh(resultHigh),
		.resultLow(resultLow)
	);

	nonRestoringDivider i_nonRestoringDivider (
		.clock(clock),
		.arstN(arstN),
		.divStart(divStart),
		.dividend(dividend),
		.divisor(divisor),
		.divDone(divDone),
		.quotient(quotient),
		.remainder(remainder)
	);

endmodule

//--- source/executeSequencer.sv
/* One instruction at a time: 3 cycles start to done, 35 for DIV.
   A start while busy is dropped; unknown opcodes write nothing. */
`timescale 1ns/1ps

module executeSequencer #(
	parameter int NUM_REGS = 16
) (
	input logic clock,
	input logic arstN,
	input logic start,
	input cpuAluPkg::aluOpE opcode,
	input logic [$clog2(NUM_REGS)-1:0] srcA,
	input logic [$clog2(NUM_REGS)-1:0] srcB,
	input logic [$clog2(NUM_REGS)-1:0] dest,
	output logic busy,
	output logic done,
	output logic [$clog2(NUM_REGS)-1:0] rdAddrA,
	output logic [$clog2(NUM_REGS)-1:0] rdAddrB,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] rdDataA,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] rdDataB,
	output cpuAluPkg::aluOpE aluOp,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] yA,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] yB,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] resultHigh,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] resultLow,
	output logic divStart,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] dividend,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] divisor,
	input logic divDone,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] quotient,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] remainder,
	output logic wbEn,
	output logic [$clog2(NUM_REGS)-1:0] wbAddr,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] wbData,
	output logic hiLoEn,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] hiData,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] loData
);
	import cpuAluPkg::*;

	localparam int ADDR_W = $clog2(NUM_REGS);

	seqStateE state;
	aluOpE opReg;
	logic [ADDR_W-1:0] destReg;
	// z register, high and low halves
	logic [DATA_WIDTH-1:0] zHigh;
	logic [DATA_WIDTH-1:0] zLow;
	logic knownOp;
	logic toHiLo;

	// operands are read while idle so Y is loaded on the start edge
	assign rdAddrA = srcA;
	assign rdAddrB = srcB;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			done <= 1'b0;
		end else begin
			done <= (state == WRITEBACK);
			case (state)
				IDLE: begin
					if (start) begin
						state <= (opcode == DIV) ? OPERAND : EXECUTE;
					end
				end
				// divStart pulses here for exactly one cycle
				OPERAND: state <= DIVIDE;
				EXECUTE: state <= WRITEBACK;
				DIVIDE: begin
					if (divDone) begin
						state <= WRITEBACK;
					end
				end
				WRITEBACK: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// instruction latch, Y and Z
	always_ff @(posedge clock) begin
		if (state == IDLE && start) begin
			opReg <= opcode;
			destReg <= dest;
			yA <= rdDataA;
			yB <= rdDataB;
		end
		if (state == EXECUTE) begin
			zHigh <= resultHigh;
			zLow <= resultLow;
		end else if (state == DIVIDE && divDone) begin
			// remainder in z high, quotient in z low
			zHigh <= remainder;
			zLow <= quotient;
		end
	end

	assign busy = (state != IDLE);
	assign aluOp = opReg;

	assign divStart = (state == OPERAND);
	assign dividend = yA;
	assign divisor = yB;

	// which writeback applies
	assign toHiLo = (opReg == MUL) || (opReg == DIV);
	assign knownOp = opReg inside {ADD, SUB, SHR, SHRA, SHL, ROR, ROL, AND, OR,
		MUL, DIV, NEG, NOT, INCPC};

	assign wbEn = (state == WRITEBACK) && knownOp && !toHiLo;
	assign wbAddr = destReg;
	assign wbData = zLow;
	assign hiLoEn = (state == WRITEBACK) && toHiLo;
	assign hiData = zHigh;
	assign loData = zLow;

	assert property (@(posedge clock) disable iff (!arstN) done |=> !done)
		else $error("done held longer than one cycle");

	// the extra start is dropped, this only reports it
	assert property (@(posedge clock) disable iff (!arstN) start |-> !busy)
		else $warning("start while busy ignored");

endmodule

//--- source/nonRestoringDivider.sv
/* Unsigned non-restoring divide, one step per clock; divDone comes 32 cycles
   after divStart. Divide by zero gives all-ones quotient, remainder = dividend. */
`timescale 1ns/1ps

module nonRestoringDivider (
	input logic clock,
	input logic arstN,
	input logic divStart,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] dividend,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] divisor,
	output logic divDone,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] quotient,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] remainder
);
	import cpuAluPkg::*;

	localparam int COUNT_BITS = $clog2(DATA_WIDTH);

	// 33-bit partial remainder, sign in the top bit
	logic [DATA_WIDTH:0] partial;
	logic [DATA_WIDTH-1:0] quoReg;
	logic [DATA_WIDTH-1:0] divReg;
	logic [COUNT_BITS-1:0] stepCount;
	logic running;

	logic [DATA_WIDTH:0] pCur;
	logic [DATA_WIDTH-1:0] qCur;
	logic [DATA_WIDTH-1:0] dCur;
	logic [DATA_WIDTH:0] pShift;
	logic [DATA_WIDTH:0] pNext;
	logic [DATA_WIDTH-1:0] qNext;

	// first step runs on the start edge straight from the inputs
	assign pCur = divStart ? '0 : partial;
	assign qCur = divStart ? dividend : quoReg;
	assign dCur = divStart ? divisor : divReg;

	// shift {p, q} left one
	assign pShift = {pCur[DATA_WIDTH-1:0], qCur[DATA_WIDTH-1]};

	// subtract when p is non-negative, add back when negative
	always_comb begin
		if (pCur[DATA_WIDTH]) begin
			pNext = pShift + {1'b0, dCur};
		end else begin
			pNext = pShift - {1'b0, dCur};
		end
	end

	// quotient bit is set when the new remainder is non-negative
	assign qNext = {qCur[DATA_WIDTH-2:0], ~pNext[DATA_WIDTH]};

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			running <= 1'b0;
			stepCount <= '0;
			divDone <= 1'b0;
		end else begin
			divDone <= 1'b0;
			if (divStart) begin
				running <= 1'b1;
				stepCount <= COUNT_BITS'(1);
			end else if (running) begin
				stepCount <= stepCount + 1'b1;
				// all-ones count means this edge does step 32
				if (&stepCount) begin
					running <= 1'b0;
					divDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (divStart || running) begin
			partial <= pNext;
			quoReg <= qNext;
			divReg <= dCur;
		end
	end

	assign quotient = quoReg;

	// final correction, a negative remainder gets the divisor back
	always_comb begin
		if (partial[DATA_WIDTH]) begin
			remainder = partial[DATA_WIDTH-1:0] + divReg;
		end else begin
			remainder = partial[DATA_WIDTH-1:0];
		end
	end

	// a new divide must not cut into one in progress
	assert property (@(posedge clock) disable iff (!arstN) divStart |-> !running)
		else $error("divider restarted while iterating");

endmodule

//--- source/registerFile.sv
/* General registers plus HI/LO, all cleared by reset.
   Reads are combinational; writeback wins over the load port. */
`timescale 1ns/1ps

module registerFile #(
	parameter int NUM_REGS = 16
) (
	input logic clock,
	input logic arstN,
	input logic loadEn,
	input logic [$clog2(NUM_REGS)-1:0] loadAddr,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] loadData,
	input logic [$clog2(NUM_REGS)-1:0] rdAddrA,
	input logic [$clog2(NUM_REGS)-1:0] rdAddrB,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] rdDataA,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] rdDataB,
	input logic [$clog2(NUM_REGS)-1:0] readAddr,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] readData,
	input logic wbEn,
	input logic [$clog2(NUM_REGS)-1:0] wbAddr,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] wbData,
	input logic hiLoEn,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] hiData,
	input logic [cpuAluPkg::DATA_WIDTH-1:0] loData,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] hi,
	output logic [cpuAluPkg::DATA_WIDTH-1:0] lo
);
	import cpuAluPkg::*;

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbAddr] <= wbData;
		end else if (loadEn) begin
			regs[loadAddr] <= loadData;
		end
	end

	// HI gets the high word, LO the low word of MUL and DIV
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hi <= '0;
			lo <= '0;
		end else if (hiLoEn) begin
			hi <= hiData;
			lo <= loData;
		end
	end

	// two operand ports and one readback port
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];
	assign readData = regs[readAddr];

endmodule

//--- verif/cpuExecuteUnitTests.svh
/* Directed tests, included inside cpuExecuteUnitTb; they use registers 1 to 4.
   Random operands come from the seeded $urandom stream. */
`ifndef CPU_EXECUTE_UNIT_TESTS_SVH
`define CPU_EXECUTE_UNIT_TESTS_SVH

// status low and every register cleared after reset
task automatic testResetIdle();
	logic [DATA_WIDTH-1:0] value;
	beginTest("reset and idle");
	compareWord("busy", '0, DATA_WIDTH'(busy));
	compareWord("done", '0, DATA_WIDTH'(done));
	for (int r = 0; r < NUM_REGS; r++) begin
		readReg(ADDR_W'(r), value);
		compareWord($sformatf("r%0d", r), '0, value);
	end
	compareWord("hi", '0, hi);
	compareWord("lo", '0, lo);
	endTest();
endtask

task automatic testLogicArith();
	aluOpE ops[7];
	logic [DATA_WIDTH-1:0] corners[6];
	logic [DATA_WIDTH-1:0] a;
	logic [DATA_WIDTH-1:0] b;
	ops = '{ADD, SUB, AND, OR, NEG, NOT, INCPC};
	corners = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
		32'h8000_0000, 32'hAAAA_5555};
	beginTest("logic and arithmetic");
	// each corner against the next, wrapping round
	foreach (corners[i]) begin
		foreach (ops[k]) begin
			runOp(ops[k], corners[i], corners[(i + 1) % 6]);
		end
	end
	for (int p = 0; p < 20; p++) begin
		a = $urandom();
		b = $urandom();
		foreach (ops[k]) begin
			runOp(ops[k], a, b);
		end
	end
	endTest();
endtask

// zero fill, sign fill and rotation modulo 32
task automatic testShifts();
	aluOpE ops[5];
	logic [DATA_WIDTH-1:0] amounts[5];
	logic [DATA_WIDTH-1:0] values[2];
	ops = '{SHR, SHRA, SHL, ROR, ROL};
	amounts = '{32'd0, 32'd1, 32'd31, 32'd32, 32'd37};
	values = '{32'h8765_4321, 32'h1234_5678};
	beginTest("shifts and rotates");
	foreach (values[v]) begin
		foreach (amounts[s]) begin
			foreach (ops[k]) begin
				runOp(ops[k], values[v], amounts[s]);
			end
		end
	end
	endTest();
endtask

task automatic testMultiply();
	logic [DATA_WIDTH-1:0] lhs[8];
	logic [DATA_WIDTH-1:0] rhs[8];
	beginTest("signed multiply");
	lhs = '{32'd3, 32'hFFFF_FFF9, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
		32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'd12345};
	rhs = '{32'd5, 32'd9, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
		32'h8000_0000, 32'd1, 32'h7FFF_FFFF, 32'hFFFF_E57B};
	foreach (lhs[i]) begin
		runOp(MUL, lhs[i], rhs[i]);
	end
	repeat (4) begin
		runOp(MUL, $urandom(), $urandom());
	end
	endTest();
endtask

// quotient to LO, remainder to HI, 35 cycles each
task automatic testDivide();
	logic [DATA_WIDTH-1:0] lhs[8];
	logic [DATA_WIDTH-1:0] rhs[8];
	logic [DATA_WIDTH-1:0] b;
	beginTest("unsigned divide");
	lhs = '{32'd100, 32'd7, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
		32'h8000_0000, 32'd0, 32'd12345, 32'hFFFF_FFFF};
	// last two are divide by zero
	rhs = '{32'd7, 32'd100, 32'd1, 32'hFFFF_FFFF,
		32'd3, 32'd5, 32'd0, 32'd0};
	foreach (lhs[i]) begin
		runOp(DIV, lhs[i], rhs[i]);
	end
	repeat (6) begin
		// shorter divisors now and then
		b = $urandom() >> ($urandom() % 24);
		runOp(DIV, $urandom(), b);
	end
	endTest();
endtask

task automatic testUnknownAndIgnored();
	logic [2*DATA_WIDTH-1:0] expected;
	logic [DATA_WIDTH-1:0] value;
	logic [DATA_WIDTH-1:0] hiBefore;
	logic [DATA_WIDTH-1:0] loBefore;
	int cycles;
	int extraDone;
	beginTest("unknown opcode and ignored start");
	loadReg(REG_A, 32'h0000_1111);
	loadReg(REG_B, 32'h0000_2222);
	loadReg(REG_D, 32'hDEAD_BEEF);
	loadReg(REG_E, 32'h4444_4444);
	hiBefore = hi;
	loBefore = lo;
	// 11111 is not a documented code
	pulseStart(aluOpE'(5'b11111), REG_A, REG_B, REG_D);
	awaitDone(cycles);
	compareOp("unknown", aluOpE'(5'b11111), 3, cycles);
	readReg(REG_D, value);
	compareWord("unknown dest", 32'hDEAD_BEEF, value);
	compareWord("unknown hi", hiBefore, hi);
	compareWord("unknown lo", loBefore, lo);
	// SUB start arrives while the DIV is still iterating
	pulseStart(DIV, REG_D, REG_A, REG_D);
	pulseStart(SUB, REG_B, REG_A, REG_E);
	awaitDone(cycles);
	expected = modelResult(DIV, 32'hDEAD_BEEF, 32'h0000_1111);
	compareWord("first hi", expected[2*DATA_WIDTH-1:DATA_WIDTH], hi);
	compareWord("first lo", expected[DATA_WIDTH-1:0], lo);
	readReg(REG_E, value);
	compareWord("ignored dest", 32'h4444_4444, value);
	extraDone = 0;
	repeat (6) begin
		@(posedge clock);
		if (done) begin
			extraDone++;
		end
	end
	checkCount++;
	if (extraDone != 0) begin
		errorCount++;
		$display("%s: a second done pulse followed the ignored start", currentTest);
	end
	endTest();
endtask

`endif

//--- verif/cpuExecuteUnitTb.sv
/* Directed testbench for cpuExecuteUnit with NUM_REGS = 16.
   Expected values come from a behavioral model of the opcode rules. */
`timescale 1ns/1ps

module cpuExecuteUnitTb;
	import cpuAluPkg::*;

	localparam int NUM_REGS = 16;
	localparam int ADDR_W = $clog2(NUM_REGS);
	// edges allowed for one done before giving up on it
	localparam int DONE_WAIT = 60;
	// operand, destination and spare registers used by the tests
	localparam logic [ADDR_W-1:0] REG_A = 1;
	localparam logic [ADDR_W-1:0] REG_B = 2;
	localparam logic [ADDR_W-1:0] REG_D = 3;
	localparam logic [ADDR_W-1:0] REG_E = 4;

	logic clock;
	logic arstN;
	logic loadEn;
	logic [ADDR_W-1:0] loadAddr;
	logic [DATA_WIDTH-1:0] loadData;
	logic [ADDR_W-1:0] readAddr;
	logic [DATA_WIDTH-1:0] readData;
	logic start;
	aluOpE opcode;
	logic [ADDR_W-1:0] srcA;
	logic [ADDR_W-1:0] srcB;
	logic [ADDR_W-1:0] dest;
	logic busy;
	logic done;
	logic [DATA_WIDTH-1:0] hi;
	logic [DATA_WIDTH-1:0] lo;

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int issuedCount = 0;
	int cycleCount = 0;
	int testErrStart = 0;
	int testCheckStart = 0;
	string currentTest = "";

	cpuExecuteUnit #(
		.NUM_REGS(NUM_REGS)
	) i_cpuExecuteUnit (
		.clock(clock),
		.arstN(arstN),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.readAddr(readAddr),
		.readData(readData),
		.start(start),
		.opcode(opcode),
		.srcA(srcA),
		.srcB(srcB),
		.dest(dest),
		.busy(busy),
		.done(done),
		.hi(hi),
		.lo(lo)
	);

	// 4 ns clock
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// watchdog, 40 cycles for each issued instruction on top of 200
	initial begin
		seqStateE dbgState;
		while (cycleCount <= 40 * issuedCount + 200) begin
			@(posedge clock);
			cycleCount++;
		end
		dbgState = i_cpuExecuteUnit.i_executeSequencer.state;
		$display("run stopped by the cycle limit after %0d cycles, sequencer in %s",
			cycleCount, dbgState.name());
		$display("ERRORS FOUND");
		$finish;
	end

	// expected {high, low} for one opcode, straight from the opcode rules
	function automatic logic [2*DATA_WIDTH-1:0] modelResult(input aluOpE op,
		input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
		logic [DATA_WIDTH-1:0] high;
		logic [DATA_WIDTH-1:0] low;
		logic signed [2*DATA_WIDTH-1:0] wideA;
		logic signed [2*DATA_WIDTH-1:0] wideB;
		int n;
		high = '0;
		low = '0;
		n = b % DATA_WIDTH;
		wideA = $signed(a);
		wideB = $signed(b);
		case (op)
			ADD: low = a + b;
			SUB: low = a - b;
			SHR: low = (b >= DATA_WIDTH) ? '0 : a >> n;
			SHRA: begin
				if (b >= DATA_WIDTH) begin
					low = {DATA_WIDTH{a[DATA_WIDTH-1]}};
				end else begin
					low = a >> n;
					// sign bits into the vacated top positions
					if (a[DATA_WIDTH-1]) begin
						low = low | ~({DATA_WIDTH{1'b1}} >> n);
					end
				end
			end
			SHL: low = (b >= DATA_WIDTH) ? '0 : a << n;
			ROR: low = (a >> n) | (a << (DATA_WIDTH - n));
			ROL: low = (a << n) | (a >> (DATA_WIDTH - n));
			AND: low = a & b;
			OR: low = a | b;
			MUL: {high, low} = wideA * wideB;
			DIV: begin
				// remainder to HI, quotient to LO
				if (b == 0) begin
					high = a;
					low = '1;
				end else begin
					high = a % b;
					low = a / b;
				end
			end
			NEG: low = -b;
			NOT: low = ~b;
			INCPC: low = b + 1;
			default: low = '0;
		endcase
		return {high, low};
	endfunction

	task automatic compareWord(input string label, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED %s %s: expected %h, actual %h", currentTest, label, expected, actual);
		end
	endtask

	// done latency in edges, counted from the edge that samples start
	task automatic compareOp(input string label, input aluOpE op, input int expected,
		input int actual);
		checkCount++;
		if (actual != expected) begin
			errorCount++;
			$display("FAILED %s %s latency of %s: expected %0d, actual %0d", currentTest,
				label, op.name(), expected, actual);
		end
	endtask

	task automatic beginTest(input string name);
		currentTest = name;
		testErrStart = errorCount;
		testCheckStart = checkCount;
	endtask

	task automatic endTest();
		testCount++;
		$display("%s: %0d checks, %0d errors", currentTest, checkCount - testCheckStart,
			errorCount - testErrStart);
	endtask

	task automatic loadReg(input logic [ADDR_W-1:0] addr, input logic [DATA_WIDTH-1:0] data);
		@(posedge clock);
		loadEn <= 1'b1;
		loadAddr <= addr;
		loadData <= data;
		@(posedge clock);
		loadEn <= 1'b0;
	endtask

	// readData is combinational, sampled one edge after the address
	task automatic readReg(input logic [ADDR_W-1:0] addr, output logic [DATA_WIDTH-1:0] data);
		@(posedge clock);
		readAddr <= addr;
		@(posedge clock);
		data = readData;
	endtask

	task automatic pulseStart(input aluOpE op, input logic [ADDR_W-1:0] a,
		input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] d);
		@(posedge clock);
		start <= 1'b1;
		opcode <= op;
		srcA <= a;
		srcB <= b;
		dest <= d;
		issuedCount++;
		@(posedge clock);
		start <= 1'b0;
	endtask

	// returns -1 when done never shows up
	task automatic awaitDone(output int cycles);
		seqStateE dbgState;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
			// busy is already up in the first cycle after start
			if (cycles == 1) begin
				compareWord("busy after start", DATA_WIDTH'(1), DATA_WIDTH'(busy));
			end
		end while (done !== 1'b1 && cycles < DONE_WAIT);
		if (done !== 1'b1) begin
			errorCount++;
			dbgState = i_cpuExecuteUnit.i_executeSequencer.state;
			$display("%s: done did not arrive within %0d cycles, sequencer in %s",
				currentTest, DONE_WAIT, dbgState.name());
			cycles = -1;
		end
	endtask

	// one instruction on registers 1 and 2, result into 3 or HI/LO
	task automatic runOp(input aluOpE op, input logic [DATA_WIDTH-1:0] a,
		input logic [DATA_WIDTH-1:0] b);
		logic [2*DATA_WIDTH-1:0] expected;
		logic [DATA_WIDTH-1:0] result;
		string label;
		int cycles;
		expected = modelResult(op, a, b);
		label = $sformatf("%s %h %h", op.name(), a, b);
		loadReg(REG_A, a);
		loadReg(REG_B, b);
		pulseStart(op, REG_A, REG_B, REG_D);
		awaitDone(cycles);
		compareOp(label, op, (op == DIV) ? 35 : 3, cycles);
		compareWord({label, " busy at done"}, '0, DATA_WIDTH'(busy));
		if (op == MUL || op == DIV) begin
			compareWord({label, " hi"}, expected[2*DATA_WIDTH-1:DATA_WIDTH], hi);
			compareWord({label, " lo"}, expected[DATA_WIDTH-1:0], lo);
		end else begin
			readReg(REG_D, result);
			compareWord(label, expected[DATA_WIDTH-1:0], result);
		end
	endtask

	`include "cpuExecuteUnitTests.svh"

	initial begin
		void'($urandom(32'h6036_238e));
		arstN = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		readAddr = '0;
		start = 1'b0;
		opcode = ADD;
		srcA = '0;
		srcB = '0;
		dest = '0;
		repeat (8) @(posedge clock);
		arstN <= 1'b1;
		@(posedge clock);
		testResetIdle();
		testLogicArith();
		testShifts();
		testMultiply();
		testDivide();
		testUnknownAndIgnored();
		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
